// File: common/revo_pkg.sv
package revo_pkg;

	// Serializer depth, fixed by the OSERDES hardware
	localparam int bits_per_word = 8;

	// Bit position within a revolution
	localparam int phase_width = 13;

	// Divider of the bit clock
	typedef enum logic [1:0] {
		div2  = 2'd0, // 10101010
		div4  = 2'd1, // 11001100
		div8  = 2'd2, // 11110000
		div16 = 2'd3  // All ones, then all zeros
	} clock_mode_t;

	typedef struct packed {
		clock_mode_t mode;
		logic        enable; // Word is zero when low
	} clock_setting_t;

	typedef struct packed {
		logic [phase_width-1:0] phase;
		logic                   enable;
	} revo_setting_t;

	// One word of a lane plus its period-start flag
	typedef struct packed {
		logic [bits_per_word-1:0] word;
		logic                     first;
	} lane_word_t;

	// Pair handed to the two serializers
	typedef struct packed {
		logic [bits_per_word-1:0] clock_word;
		logic [bits_per_word-1:0] revo_word;
	} serial_words_t;

endpackage

// File: rtl/handshake_register.sv
`timescale 1ns/100ps

module handshake_register #(
	parameter type payload_t = logic
) (
	input  logic     clock50,
	input  logic     reset,
	input  logic     req,
	output logic     ack,
	input  payload_t data_in,
	output payload_t data_out,
	output logic     update
);

	logic req_meta;
	logic req_sync;

	// Two-flop synchronizer on the request
	always_ff @(posedge clock50) begin
		if (reset) begin
			req_meta <= 1'b0;
			req_sync <= 1'b0;
		end else begin
			req_meta <= req;
			req_sync <= req_meta;
		end
	end

	// The writer holds data_in stable while req is high
	always_ff @(posedge clock50) begin
		if (reset) begin
			ack      <= 1'b0;
			update   <= 1'b0;
			data_out <= '0; // Generators start disabled
		end else begin
			update <= 1'b0;
			if (req_sync && !ack) begin
				// New request seen
				data_out <= data_in;
				ack      <= 1'b1;
				update   <= 1'b1;
			end else if (!req_sync && ack) begin
				ack <= 1'b0; // Writer dropped req, close the cycle
			end
		end
	end

endmodule

// File: rtl/clock_pattern_gen.sv
`timescale 1ns/100ps

module clock_pattern_gen
	import revo_pkg::*;
(
	input  logic           clock50,
	input  logic           reset,
	input  logic           req,
	output logic           ack,
	input  clock_setting_t setting,
	output lane_word_t     lane
);

	clock_setting_t captured;
	clock_setting_t pending;
	clock_setting_t active;
	clock_setting_t use_setting;
	logic           update;
	logic           change_pending;
	logic           half; // Second word of a div16 period
	logic           period_start;
	logic [bits_per_word-1:0] pattern;

	handshake_register #(
		.payload_t(clock_setting_t)
	) i_handshake_register (
		.clock50 (clock50),
		.reset   (reset),
		.req     (req),
		.ack     (ack),
		.data_in (setting),
		.data_out(captured),
		.update  (update)
	);

	assign period_start = !half;
	// A waiting change is applied only at a period start
	assign use_setting = (period_start && change_pending) ? pending : active;

	always_comb begin
		case (use_setting.mode)
			div2:    pattern = 8'b1010_1010;
			div4:    pattern = 8'b1100_1100;
			div8:    pattern = 8'b1111_0000;
			default: pattern = half ? 8'h00 : 8'hff;
		endcase
		if (!use_setting.enable) begin
			pattern = '0;
		end
	end

	always_ff @(posedge clock50) begin
		if (reset) begin
			pending        <= '0;
			change_pending <= 1'b0;
			active         <= '0;
			half           <= 1'b0;
			lane           <= '0;
		end else begin
			if (update) begin
				pending        <= captured;
				change_pending <= 1'b1;
			end else if (period_start) begin
				change_pending <= 1'b0;
			end
			active <= use_setting;
			// Only div16 has a two-word period
			half       <= (use_setting.mode == div16) ? !half : 1'b0;
			lane.word  <= pattern;
			lane.first <= period_start;
		end
	end

endmodule

// File: revo_marker/revo_marker_gen.sv
`timescale 1ns/100ps

module revo_marker_gen
	import revo_pkg::*;
#(
	parameter int revolution_words = 640
) (
	input  logic          clock50,
	input  logic          reset,
	input  logic          req,
	output logic          ack,
	input  revo_setting_t setting,
	output lane_word_t    lane
);

	localparam int revolution_bits = revolution_words * bits_per_word;
	localparam int bit_index_width = $clog2(bits_per_word);
	localparam int index_width     = phase_width - bit_index_width;

	revo_setting_t              captured;
	revo_setting_t              pending;
	revo_setting_t              active;
	logic                       update;
	logic [index_width-1:0]     word_count;
	logic                       wrap;
	logic [index_width-1:0]     word_index;
	logic [bit_index_width-1:0] bit_index;
	logic [bits_per_word-1:0]   marker_word;

	handshake_register #(
		.payload_t(revo_setting_t)
	) i_handshake_register (
		.clock50 (clock50),
		.reset   (reset),
		.req     (req),
		.ack     (ack),
		.data_in (setting),
		.data_out(captured),
		.update  (update)
	);

	assign wrap = (word_count == index_width'(revolution_words - 1));

	// Phase splits into word within revolution and bit within word
	assign word_index = active.phase[phase_width-1:bit_index_width];
	assign bit_index  = active.phase[bit_index_width-1:0];

	always_comb begin
		marker_word = '0;
		if (active.enable && (word_count == word_index)) begin
			// Bit 7 leaves the serializer first
			marker_word[bits_per_word-1-bit_index] = 1'b1;
		end
	end

	always_ff @(posedge clock50) begin
		if (reset) begin
			pending    <= '0;
			active     <= '0;
			word_count <= '0;
			lane       <= '0;
		end else begin
			if (update) begin
				pending <= captured;
			end
			if (wrap) begin
				word_count    <= '0;
				// New setting only between revolutions
				active.enable <= pending.enable;
				active.phase  <= phase_width'(pending.phase % revolution_bits);
			end else begin
				word_count <= word_count + 1'b1;
			end
			lane.word  <= marker_word;
			lane.first <= (word_count == '0);
		end
	end

endmodule

// File: rtl/lane_merger.sv
`timescale 1ns/100ps

module lane_merger
	import revo_pkg::*;
#(
	parameter int revolution_count_width = 16
) (
	input  logic                              clock50,
	input  logic                              reset,
	input  lane_word_t                        clock_lane,
	input  lane_word_t                        revo_lane,
	output serial_words_t                     serial_words,
	output logic                              words_valid,
	output logic                              revolution_marker,
	output logic [revolution_count_width-1:0] revolution_count
);

	logic started;
	logic forward;

	// Output opens on the first revolution start
	assign forward = started || revo_lane.first;

	assign words_valid = started;

	always_ff @(posedge clock50) begin
		if (reset) begin
			started <= 1'b0;
		end else if (revo_lane.first) begin
			started <= 1'b1;
		end
	end

	always_ff @(posedge clock50) begin
		if (reset) begin
			serial_words      <= '0;
			revolution_marker <= 1'b0;
			revolution_count  <= '0;
		end else begin
			if (forward) begin
				serial_words.clock_word <= clock_lane.word;
				serial_words.revo_word  <= revo_lane.word;
			end else begin
				serial_words <= '0; // Quiet until aligned
			end
			revolution_marker <= forward && (revo_lane.word != '0);
			if (revo_lane.first) begin
				revolution_count <= revolution_count + 1'b1;
			end
		end
	end

endmodule

// File: rtl/clock_revo_top.sv
`timescale 1ns/100ps

module clock_revo_top
	import revo_pkg::*;
#(
	parameter int revolution_words       = 640, // 5120 buckets
	parameter int revolution_count_width = 16
) (
	input  logic                              clock50,
	input  logic                              reset,
	input  logic                              clock_req,
	output logic                              clock_ack,
	input  clock_setting_t                    clock_setting,
	input  logic                              revo_req,
	output logic                              revo_ack,
	input  revo_setting_t                     revo_setting,
	output serial_words_t                     serial_words,
	output logic                              words_valid,
	output logic                              revolution_marker,
	output logic [revolution_count_width-1:0] revolution_count
);

	lane_word_t clock_lane;
	lane_word_t revo_lane;

	clock_pattern_gen i_clock_pattern_gen (
		.clock50(clock50),
		.reset  (reset),
		.req    (clock_req),
		.ack    (clock_ack),
		.setting(clock_setting),
		.lane   (clock_lane)
	);

	revo_marker_gen #(
		.revolution_words(revolution_words)
	) i_revo_marker_gen (
		.clock50(clock50),
		.reset  (reset),
		.req    (revo_req),
		.ack    (revo_ack),
		.setting(revo_setting),
		.lane   (revo_lane)
	);

	lane_merger #(
		.revolution_count_width(revolution_count_width)
	) i_lane_merger (
		.clock50          (clock50),
		.reset            (reset),
		.clock_lane       (clock_lane),
		.revo_lane        (revo_lane),
		.serial_words     (serial_words),
		.words_valid      (words_valid),
		.revolution_marker(revolution_marker),
		.revolution_count (revolution_count)
	);

endmodule

// File: bench/clock_revo_tb.sv
`timescale 1ns/100ps

module clock_revo_tb
	import revo_pkg::*;
();

	localparam int revolution_words    = 40;
	localparam int revolution_bits     = revolution_words * bits_per_word;
	localparam int cycle_limit         = 12 * revolution_words + 200;
	localparam int start_limit         = revolution_words + 3;
	localparam int handshake_limit     = 10;
	localparam int clock_apply_delay   = 3; // Ack edge to first serial word that may change
	localparam int revolutions_written = 9;

	logic           clock50;
	logic           reset;
	logic           clock_req;
	logic           clock_ack;
	clock_setting_t clock_setting;
	logic           revo_req;
	logic           revo_ack;
	revo_setting_t  revo_setting;
	serial_words_t  serial_words;
	logic           words_valid;
	logic           revolution_marker;
	logic [15:0]    revolution_count;

	logic [31:0] lcg_state   = 32'h2910f642;
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;
	int          start_wait  = 0;
	bit          start_late  = 0;

	// Reference model state
	bit             model_running  = 0;
	int             word_index     = 0; // Index of the next word to arrive
	int             model_count    = 0;
	clock_setting_t clock_active   = '0;
	clock_setting_t clock_pend     = '0;
	bit             clock_has_pend = 0;
	int             clock_age      = 0;
	logic           clock_half     = 0; // Second word of a div16 period
	revo_setting_t  revo_active    = '0;
	revo_setting_t  revo_pend      = '0;
	bit             revo_has_pend  = 0;
	logic [7:0]     expected_clock;
	logic [7:0]     expected_revo;

	// Handshake watch
	logic clock_ack_prev = 0;
	logic clock_req_prev = 0;
	logic revo_ack_prev  = 0;
	logic revo_req_prev  = 0;
	int   clock_acks     = 0;
	int   revo_acks      = 0;

	clock_revo_top #(
		.revolution_words(revolution_words)
	) i_clock_revo_top (
		.clock50          (clock50),
		.reset            (reset),
		.clock_req        (clock_req),
		.clock_ack        (clock_ack),
		.clock_setting    (clock_setting),
		.revo_req         (revo_req),
		.revo_ack         (revo_ack),
		.revo_setting     (revo_setting),
		.serial_words     (serial_words),
		.words_valid      (words_valid),
		.revolution_marker(revolution_marker),
		.revolution_count (revolution_count)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int pick(input int range);
		logic [31:0] value;
		value = next_random();
		return int'(value[31:8] % range); // Low bits of an LCG repeat quickly
	endfunction

	function automatic logic [7:0] clock_pattern(input clock_setting_t s, input logic second_half);
		logic [7:0] word;
		case (s.mode)
			div2:    word = 8'haa;
			div4:    word = 8'hcc;
			div8:    word = 8'hf0;
			default: word = second_half ? 8'h00 : 8'hff;
		endcase
		return s.enable ? word : 8'h00;
	endfunction

	// One-hot marker, bit 7 is the earliest bucket of a word
	function automatic logic [7:0] marker_word(input revo_setting_t s, input int index);
		int position;
		position = s.phase % revolution_bits;
		if (s.enable && index == position / bits_per_word) begin
			return 8'h80 >> (position % bits_per_word);
		end
		return 8'h00;
	endfunction

	function automatic logic port_ack(input bit to_revo);
		return to_revo ? revo_ack : clock_ack;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERROR %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic next_cycle();
		@(posedge clock50);
		#0.5;
	endtask

	task automatic wait_for_index(input int target);
		while (word_index != target) begin
			next_cycle();
		end
	endtask

	// Full four-phase write, req held for hold extra cycles past ack
	task automatic write_setting(input bit to_revo, input logic [13:0] value, input int hold);
		int acks_before;
		int waited;
		acks_before = to_revo ? revo_acks : clock_acks;
		if (to_revo) begin
			revo_setting = value;
			revo_req     = 1'b1;
		end else begin
			clock_setting = value[2:0];
			clock_req     = 1'b1;
		end
		waited = 0;
		while (!port_ack(to_revo) && waited < handshake_limit) begin
			next_cycle();
			waited++;
		end
		if (!port_ack(to_revo)) begin
			error_count++;
			$display("%s port: ack did not rise while req was high", to_revo ? "revo" : "clock");
		end
		repeat (hold) next_cycle();
		if (to_revo) begin
			revo_req = 1'b0;
		end else begin
			clock_req = 1'b0;
		end
		waited = 0;
		while (port_ack(to_revo) && waited < handshake_limit) begin
			next_cycle();
			waited++;
		end
		if (port_ack(to_revo)) begin
			error_count++;
			$display("%s port: ack stayed high after req fell", to_revo ? "revo" : "clock");
		end
		if ((to_revo ? revo_acks : clock_acks) - acks_before != 1) begin
			error_count++;
			$display("%s port: one write was acknowledged %0d times", to_revo ? "revo" : "clock",
				(to_revo ? revo_acks : clock_acks) - acks_before);
		end
	endtask

	initial begin : clock_gen
		clock50 = 1'b0;
		forever #2 clock50 = ~clock50;
	end

	// Monitor and model, sampled mid-cycle where outputs are settled
	always @(negedge clock50) begin
		if (clock_ack && !clock_ack_prev) begin
			check_value("clock_req at clock_ack rise", clock_req_prev, 1);
			clock_acks++;
			clock_pend     = clock_setting;
			clock_has_pend = 1'b1;
			clock_age      = 0;
		end
		if (!clock_ack && clock_ack_prev) begin
			check_value("clock_req at clock_ack fall", clock_req_prev, 0);
		end
		if (revo_ack && !revo_ack_prev) begin
			check_value("revo_req at revo_ack rise", revo_req_prev, 1);
			revo_acks++;
			revo_pend     = revo_setting;
			revo_has_pend = 1'b1;
		end
		if (!revo_ack && revo_ack_prev) begin
			check_value("revo_req at revo_ack fall", revo_req_prev, 0);
		end
		clock_ack_prev = clock_ack;
		clock_req_prev = clock_req;
		revo_ack_prev  = revo_ack;
		revo_req_prev  = revo_req;

		if (!model_running && words_valid) begin
			model_running = 1'b1; // First valid word opens a revolution
			word_index    = 0;
		end
		if (model_running) begin
			check_value("words_valid", words_valid, 1);
			// Clock lane changes only at a period start
			if (!clock_half && clock_has_pend && clock_age >= clock_apply_delay) begin
				clock_active   = clock_pend;
				clock_has_pend = 1'b0;
			end
			expected_clock = clock_pattern(clock_active, clock_half);
			clock_half     = (clock_active.mode == div16) ? !clock_half : 1'b0;
			if (word_index == 0) begin
				if (revo_has_pend) begin
					revo_active   = revo_pend;
					revo_has_pend = 1'b0;
				end
				model_count++;
			end
			expected_revo = marker_word(revo_active, word_index);
			check_value("serial_words.clock_word", serial_words.clock_word, expected_clock);
			check_value("serial_words.revo_word", serial_words.revo_word, expected_revo);
			check_value("revolution_marker", revolution_marker, expected_revo != 8'h00);
			check_value("revolution_count", revolution_count, model_count);
			word_index = (word_index + 1) % revolution_words;
		end else begin
			check_value("clock_ack", clock_ack, 0);
			check_value("revo_ack", revo_ack, 0);
			check_value("serial_words", serial_words, 0);
			check_value("revolution_marker", revolution_marker, 0);
			check_value("revolution_count", revolution_count, 0);
			if (!reset) begin
				start_wait++;
				if (start_wait > start_limit && !start_late) begin
					start_late = 1'b1;
					error_count++;
					$display("words_valid did not rise within %0d cycles of reset release",
						start_limit);
				end
			end
		end
		clock_age++;
	end

	initial begin : stimulus
		clock_setting_t clock_value;
		revo_setting_t  revo_value;
		int             pass_index;
		reset         = 1'b1;
		clock_req     = 1'b0;
		revo_req      = 1'b0;
		clock_setting = '0;
		revo_setting  = '0;
		repeat (10) @(posedge clock50);
		#0.5 reset = 1'b0;
		while (!model_running) begin
			next_cycle();
		end
		// One clock write and one revo write early in each revolution
		for (pass_index = 0; pass_index < revolutions_written; pass_index++) begin
			wait_for_index(2);
			clock_value.mode   = clock_mode_t'(pick(4));
			clock_value.enable = (pick(4) != 0);
			write_setting(1'b0, 14'(clock_value), pick(4));
			repeat (pick(4)) next_cycle();
			revo_value.phase  = (pick(4) == 0) ? 13'(pick(8192)) : 13'(pick(revolution_bits));
			revo_value.enable = (pick(4) != 0);
			write_setting(1'b1, revo_value, pick(4));
		end
		repeat (2 * revolution_words) next_cycle(); // Last phase shows in the next revolution
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		while (cycle_count < cycle_limit) begin
			@(posedge clock50);
			cycle_count++;
		end
		$display("Timeout, the run did not finish within %0d cycles", cycle_limit);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: build.f
common/revo_pkg.sv
rtl/handshake_register.sv
rtl/clock_pattern_gen.sv
revo_marker/revo_marker_gen.sv
rtl/lane_merger.sv
rtl/clock_revo_top.sv
bench/clock_revo_tb.sv
